// ==== common/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

//////////////////////////////
// address map
//////////////////////////////
// region codes in addr[30:28]
`define REGION_ZERO     3'd0
`define REGION_MAIN     3'd1
`define REGION_UART     3'd2
`define REGION_EXT      3'd4

// sits in unmapped region 6
`define SOFT_RESET_ADDR 32'h6FFF_FFFC

// memory depth, word address bits
`define BOOT_ADDR_W     10
`define MAIN_ADDR_W     12

//////////////////////////////
// reset and uart
//////////////////////////////
// top bit sets after 1024 cycles
`define RST_CNT_W       11
`define SOFT_RST_CYCLES 5
// clocks per bit out of reset
`define UART_DIV_RESET  16'd8

`endif

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   // native bus fields
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   // all zero strobes mean a read
   typedef logic [3:0]  strb_t;
   // address bits 30 to 28
   typedef logic [2:0]  region_t;

   // external bridge, one access at a time
   typedef enum logic [2:0] {
      BR_IDLE,
      BR_WRITE,
      BR_WRESP,
      BR_READ,
      BR_RRESP,
      BR_DONE
   } bridge_state_t;

   // 8N1 framing
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } uart_tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } uart_rx_state_t;

endpackage

`default_nettype wire

// ==== common/native_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface native_bus_if
   import soc_pkg::*;
();

   // request, held by master until ready
   logic  valid;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;
   // response, one cycle pulse
   logic  ready;
   data_t rdata;

   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rdata
   );

   // observe only
   modport monitor (
      input valid, addr, wdata, wstrb, ready, rdata
   );

endinterface

`default_nettype wire

// ==== design/reset_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module reset_ctrl (
   input  logic          clk,
   input  logic          reset,
   native_bus_if.monitor bus,
   output logic          sys_ready,
   output logic          core_reset,
   output logic          mem_sel
);

   logic [`RST_CNT_W-1:0]       rst_cnt;
   logic [`SOFT_RST_CYCLES-1:0] pulse;
   logic                        soft_hit;

   //////////////////////////////
   // power-on counter
   //////////////////////////////
   // stops once the top bit sets
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rst_cnt <= '0;
      end else if (!rst_cnt[`RST_CNT_W-1]) begin
         rst_cnt <= rst_cnt + 1'b1;
      end
   end

   assign sys_ready = rst_cnt[`RST_CNT_W-1];

   //////////////////////////////
   // soft reset
   //////////////////////////////
   // first cycle of the request only, ready not yet back
   assign soft_hit = sys_ready && bus.valid && !bus.ready &&
                     (bus.addr == `SOFT_RESET_ADDR);

   // mem_sel sticks until hard reset
   // pulse drains one bit per cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mem_sel <= 1'b0;
         pulse   <= '0;
      end else if (soft_hit) begin
         mem_sel <= 1'b1;
         pulse   <= '1;
      end else begin
         pulse <= pulse >> 1;
      end
   end

   assign core_reset = !sys_ready || pulse[0];

   // core held and boot memory kept while the counter runs
   a_core_held: assert property (@(posedge clk) disable iff (reset)
      !sys_ready |-> core_reset && !mem_sel);

   // swap and core pulse for the full length
   a_soft_pulse: assert property (@(posedge clk) disable iff (reset)
      soft_hit |=> (mem_sel && core_reset) [*`SOFT_RST_CYCLES]);

endmodule

`default_nettype wire

// ==== design/bus_interconnect.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module bus_interconnect
   import soc_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         mem_sel,
   native_bus_if.slave  master,
   native_bus_if.master boot,
   native_bus_if.master main,
   native_bus_if.master uart,
   native_bus_if.master ext
);

   region_t region;
   logic    sel_boot;
   logic    sel_main;
   logic    sel_uart;
   logic    sel_ext;
   logic    sel_none;
   logic    none_ready;

   //////////////////////////////
   // decode
   //////////////////////////////
   assign region   = master.addr[30:28];
   // region 0 follows mem_sel
   assign sel_boot = (region == `REGION_ZERO) && !mem_sel;
   assign sel_main = (region == `REGION_MAIN) || ((region == `REGION_ZERO) && mem_sel);
   assign sel_uart = (region == `REGION_UART);
   assign sel_ext  = (region == `REGION_EXT);
   assign sel_none = !(sel_boot || sel_main || sel_uart || sel_ext);

   // fields fan out, valid only to the selected slave
   assign boot.valid = master.valid && sel_boot;
   assign boot.addr  = master.addr;
   assign boot.wdata = master.wdata;
   assign boot.wstrb = master.wstrb;

   assign main.valid = master.valid && sel_main;
   assign main.addr  = master.addr;
   assign main.wdata = master.wdata;
   assign main.wstrb = master.wstrb;

   assign uart.valid = master.valid && sel_uart;
   assign uart.addr  = master.addr;
   assign uart.wdata = master.wdata;
   assign uart.wstrb = master.wstrb;

   assign ext.valid  = master.valid && sel_ext;
   assign ext.addr   = master.addr;
   assign ext.wdata  = master.wdata;
   assign ext.wstrb  = master.wstrb;

   // unmapped, answer one cycle later with zero
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         none_ready <= 1'b0;
      end else begin
         none_ready <= master.valid && sel_none && !none_ready;
      end
   end

   //////////////////////////////
   // response mux
   //////////////////////////////
   always_comb begin
      if (sel_boot) begin
         master.ready = boot.ready;
         master.rdata = boot.rdata;
      end else if (sel_main) begin
         master.ready = main.ready;
         master.rdata = main.rdata;
      end else if (sel_uart) begin
         master.ready = uart.ready;
         master.rdata = uart.rdata;
      end else if (sel_ext) begin
         master.ready = ext.ready;
         master.rdata = ext.rdata;
      end else begin
         master.ready = none_ready;
         master.rdata = '0;
      end
   end

   // one slave addressed, one response coming back
   a_one_slave: assert property (@(posedge clk) disable iff (reset)
      $onehot0({boot.valid, main.valid, uart.valid, ext.valid}) &&
      $onehot0({boot.ready, main.ready, uart.ready, ext.ready, none_ready}));

endmodule

`default_nettype wire

// ==== design/sram_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_memory
   import soc_pkg::*;
#(
   parameter int ADDR_W = 10
) (
   input logic         clk,
   native_bus_if.slave bus
);

   data_t             mem [0:(1 << ADDR_W)-1];
   logic [ADDR_W-1:0] idx;
   logic              ready_q;

   // word index, upper bits dropped
   assign idx = bus.addr[ADDR_W+1:2];

   // one ready per request
   always_ff @(posedge clk) begin
      ready_q <= bus.valid && !ready_q;
   end

   // strobed bytes, written once per request
   always_ff @(posedge clk) begin
      if (bus.valid && !ready_q) begin
         for (int b = 0; b < 4; b++) begin
            if (bus.wstrb[b]) begin
               mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
         end
      end
   end

   // registered read, old word on a write
   always_ff @(posedge clk) begin
      if (bus.valid) begin
         bus.rdata <= mem[idx];
      end
   end

   assign bus.ready = ready_q;

endmodule

`default_nettype wire

// ==== uart/uart_core.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module uart_core
   import soc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   native_bus_if.slave bus,
   output logic        ser_tx,
   input  logic        ser_rx
);

   uart_tx_state_t tx_state;
   uart_rx_state_t rx_state;
   logic [1:0]     reg_sel;
   logic           acc;
   logic           wr_en;
   logic           rd_en;
   logic           ready_q;
   logic [15:0]    divisor;
   logic [15:0]    tx_cnt;
   logic [15:0]    rx_cnt;
   logic [2:0]     tx_bit;
   logic [2:0]     rx_bit;
   logic [7:0]     tx_shift;
   logic [7:0]     rx_shift;
   logic [7:0]     rx_data;
   logic           rx_valid;
   logic [1:0]     rx_sync;
   logic           tx_busy;
   logic           tx_tick;
   logic           rx_tick;
   logic           rx_half;

   //////////////////////////////
   // register access
   //////////////////////////////
   assign reg_sel = bus.addr[3:2];
   // first cycle of a request
   assign acc     = bus.valid && !ready_q;
   assign wr_en   = acc && (bus.wstrb != '0);
   assign rd_en   = acc && (bus.wstrb == '0);
   assign tx_busy = (tx_state != TX_IDLE);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         divisor <= `UART_DIV_RESET;
      end else begin
         ready_q <= acc;
         if (wr_en && reg_sel == 2'd3) begin
            divisor <= bus.wdata[15:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (reg_sel)
            2'd1:    bus.rdata <= {30'd0, rx_valid, tx_busy};
            2'd2:    bus.rdata <= {24'd0, rx_data};
            2'd3:    bus.rdata <= {16'd0, divisor};
            default: bus.rdata <= '0;
         endcase
      end
   end

   assign bus.ready = ready_q;

   //////////////////////////////
   // transmitter
   //////////////////////////////
   assign tx_tick = (tx_cnt == divisor - 16'd1);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_state <= TX_IDLE;
         ser_tx   <= 1'b1;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_shift <= '0;
      end else begin
         tx_cnt <= tx_tick ? 16'd0 : tx_cnt + 16'd1;
         case (tx_state)
            TX_IDLE: begin
               tx_cnt <= '0;
               // writes while busy are dropped
               if (wr_en && reg_sel == 2'd0) begin
                  tx_shift <= bus.wdata[7:0];
                  ser_tx   <= 1'b0;
                  tx_state <= TX_START;
               end
            end
            TX_START: begin
               if (tx_tick) begin
                  ser_tx   <= tx_shift[0];
                  tx_bit   <= '0;
                  tx_state <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (tx_tick) begin
                  if (tx_bit == 3'd7) begin
                     ser_tx   <= 1'b1;
                     tx_state <= TX_STOP;
                  end else begin
                     // lsb first
                     ser_tx   <= tx_shift[1];
                     tx_shift <= tx_shift >> 1;
                     tx_bit   <= tx_bit + 3'd1;
                  end
               end
            end
            default: begin
               if (tx_tick) begin
                  tx_state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   //////////////////////////////
   // receiver
   //////////////////////////////
   assign rx_tick = (rx_cnt == divisor - 16'd1);
   // mid-bit of the start bit
   assign rx_half = (rx_cnt == {1'b0, divisor[15:1]} - 16'd1);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_sync  <= 2'b11;
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_shift <= '0;
         rx_data  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], ser_rx};
         rx_cnt  <= rx_tick ? 16'd0 : rx_cnt + 16'd1;
         // read of rx data clears the flag
         if (rd_en && reg_sel == 2'd2) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_sync[1]) begin
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (rx_half) begin
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  // glitch, back to idle
                  rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (rx_tick) begin
                  rx_shift <= {rx_sync[1], rx_shift[7:1]};
                  rx_bit   <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= RX_STOP;
                  end
               end
            end
            default: begin
               if (rx_tick) begin
                  // keep the byte only on a good stop bit
                  if (rx_sync[1]) begin
                     rx_data  <= rx_shift;
                     rx_valid <= 1'b1;
                  end
                  rx_state <= RX_IDLE;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/axi_lite_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_lite_bridge
   import soc_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   native_bus_if.slave bus,
   // write address
   output logic        awvalid,
   input  logic        awready,
   output addr_t       awaddr,
   // write data
   output logic        wvalid,
   input  logic        wready,
   output data_t       wdata,
   output strb_t       wstrb,
   // write response
   input  logic        bvalid,
   output logic        bready,
   // read address
   output logic        arvalid,
   input  logic        arready,
   output addr_t       araddr,
   // read data
   input  logic        rvalid,
   output logic        rready,
   input  data_t       rdata
);

   bridge_state_t state;
   data_t         rdata_q;

   // ready the cycle after the last handshake
   assign bus.ready = (state == BR_DONE);
   assign bus.rdata = rdata_q;

   //////////////////////////////
   // handshake FSM
   //////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= BR_IDLE;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         bready  <= 1'b0;
         arvalid <= 1'b0;
         rready  <= 1'b0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (bus.valid && bus.wstrb != '0) begin
                  awvalid <= 1'b1;
                  wvalid  <= 1'b1;
                  state   <= BR_WRITE;
               end else if (bus.valid) begin
                  arvalid <= 1'b1;
                  state   <= BR_READ;
               end
            end
            BR_WRITE: begin
               // aw and w drop on their own ready
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if ((!awvalid || awready) && (!wvalid || wready)) begin
                  bready <= 1'b1;
                  state  <= BR_WRESP;
               end
            end
            BR_WRESP: begin
               if (bvalid) begin
                  bready <= 1'b0;
                  state  <= BR_DONE;
               end
            end
            BR_READ: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= BR_RRESP;
               end
            end
            BR_RRESP: begin
               if (rvalid) begin
                  rready <= 1'b0;
                  state  <= BR_DONE;
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   // request and response payload
   always_ff @(posedge clk) begin
      if (state == BR_IDLE && bus.valid) begin
         awaddr <= bus.addr;
         araddr <= bus.addr;
         wdata  <= bus.wdata;
         wstrb  <= bus.wstrb;
      end
      if (state == BR_RRESP && rvalid) begin
         rdata_q <= rdata;
      end
   end

   a_aw_hold: assert property (@(posedge clk) disable iff (reset)
      awvalid && !awready |=> awvalid && $stable(awaddr));
   a_w_hold: assert property (@(posedge clk) disable iff (reset)
      wvalid && !wready |=> wvalid && $stable(wdata));
   a_ar_hold: assert property (@(posedge clk) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// ==== design/soc_system.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module soc_system
   import soc_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   // native master
   input  logic  m_valid,
   output logic  m_ready,
   input  addr_t m_addr,
   input  data_t m_wdata,
   input  strb_t m_wstrb,
   output data_t m_rdata,
   // serial
   output logic  ser_tx,
   input  logic  ser_rx,
   // reset status
   output logic  sys_ready,
   output logic  core_reset,
   output logic  mem_sel,
   // external AXI4-Lite
   output logic  m_axi_awvalid,
   input  logic  m_axi_awready,
   output addr_t m_axi_awaddr,
   output logic  m_axi_wvalid,
   input  logic  m_axi_wready,
   output data_t m_axi_wdata,
   output strb_t m_axi_wstrb,
   input  logic  m_axi_bvalid,
   output logic  m_axi_bready,
   output logic  m_axi_arvalid,
   input  logic  m_axi_arready,
   output addr_t m_axi_araddr,
   input  logic  m_axi_rvalid,
   output logic  m_axi_rready,
   input  data_t m_axi_rdata
);

   native_bus_if m_bus ();
   native_bus_if boot_bus ();
   native_bus_if main_bus ();
   native_bus_if uart_bus ();
   native_bus_if ext_bus ();

   // master ports into the bundle
   assign m_bus.valid = m_valid;
   assign m_bus.addr  = m_addr;
   assign m_bus.wdata = m_wdata;
   assign m_bus.wstrb = m_wstrb;
   assign m_ready     = m_bus.ready;
   assign m_rdata     = m_bus.rdata;

   //////////////////////////////
   // control and routing
   //////////////////////////////
   reset_ctrl i_reset_ctrl (
      .clk        (clk),
      .reset      (reset),
      .bus        (m_bus),
      .sys_ready  (sys_ready),
      .core_reset (core_reset),
      .mem_sel    (mem_sel)
   );

   bus_interconnect i_bus_interconnect (
      .clk     (clk),
      .reset   (reset),
      .mem_sel (mem_sel),
      .master  (m_bus),
      .boot    (boot_bus),
      .main    (main_bus),
      .uart    (uart_bus),
      .ext     (ext_bus)
   );

   //////////////////////////////
   // slaves
   //////////////////////////////
   sram_memory #(.ADDR_W(`BOOT_ADDR_W)) i_boot_memory (
      .clk (clk),
      .bus (boot_bus)
   );

   sram_memory #(.ADDR_W(`MAIN_ADDR_W)) i_main_memory (
      .clk (clk),
      .bus (main_bus)
   );

   uart_core i_uart_core (
      .clk    (clk),
      .reset  (reset),
      .bus    (uart_bus),
      .ser_tx (ser_tx),
      .ser_rx (ser_rx)
   );

   // region 4 goes out
   axi_lite_bridge i_axi_lite_bridge (
      .clk     (clk),
      .reset   (reset),
      .bus     (ext_bus),
      .awvalid (m_axi_awvalid),
      .awready (m_axi_awready),
      .awaddr  (m_axi_awaddr),
      .wvalid  (m_axi_wvalid),
      .wready  (m_axi_wready),
      .wdata   (m_axi_wdata),
      .wstrb   (m_axi_wstrb),
      .bvalid  (m_axi_bvalid),
      .bready  (m_axi_bready),
      .arvalid (m_axi_arvalid),
      .arready (m_axi_arready),
      .araddr  (m_axi_araddr),
      .rvalid  (m_axi_rvalid),
      .rready  (m_axi_rready),
      .rdata   (m_axi_rdata)
   );

endmodule

`default_nettype wire

// ==== tests/tb_soc_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_soc_system
   import soc_pkg::*;
();

   //////////////////////////////
   // golden op codes
   //////////////////////////////
   localparam int MAX_OPS       = 64;
   localparam int OP_END        = 0;
   localparam int OP_WRITE      = 1;
   localparam int OP_READ       = 2;
   localparam int OP_UART_WAIT  = 3;
   localparam int OP_SOFT_RESET = 4;

   logic  clk;
   logic  reset;
   logic  m_valid;
   logic  m_ready;
   addr_t m_addr;
   data_t m_wdata;
   strb_t m_wstrb;
   data_t m_rdata;
   logic  ser_tx;
   logic  ser_rx;
   logic  sys_ready;
   logic  core_reset;
   logic  mem_sel;
   logic  m_axi_awvalid;
   logic  m_axi_awready;
   addr_t m_axi_awaddr;
   logic  m_axi_wvalid;
   logic  m_axi_wready;
   data_t m_axi_wdata;
   strb_t m_axi_wstrb;
   logic  m_axi_bvalid;
   logic  m_axi_bready;
   logic  m_axi_arvalid;
   logic  m_axi_arready;
   addr_t m_axi_araddr;
   logic  m_axi_rvalid;
   logic  m_axi_rready;
   data_t m_axi_rdata;

   // five words per line: kind addr wdata strb expected
   logic [31:0] golden [0:MAX_OPS*5-1];
   int          n_ops        = 0;
   int          errors       = 0;
   int          checks       = 0;
   int          pulse_cycles = 0;
   integer      seed;
   addr_t       last_awaddr;
   addr_t       last_araddr;
   data_t       ext_mem [0:255];

   // serial loopback
   assign ser_rx = ser_tx;

   soc_system i_soc_system (
      .clk           (clk),
      .reset         (reset),
      .m_valid       (m_valid),
      .m_ready       (m_ready),
      .m_addr        (m_addr),
      .m_wdata       (m_wdata),
      .m_wstrb       (m_wstrb),
      .m_rdata       (m_rdata),
      .ser_tx        (ser_tx),
      .ser_rx        (ser_rx),
      .sys_ready     (sys_ready),
      .core_reset    (core_reset),
      .mem_sel       (mem_sel),
      .m_axi_awvalid (m_axi_awvalid),
      .m_axi_awready (m_axi_awready),
      .m_axi_awaddr  (m_axi_awaddr),
      .m_axi_wvalid  (m_axi_wvalid),
      .m_axi_wready  (m_axi_wready),
      .m_axi_wdata   (m_axi_wdata),
      .m_axi_wstrb   (m_axi_wstrb),
      .m_axi_bvalid  (m_axi_bvalid),
      .m_axi_bready  (m_axi_bready),
      .m_axi_arvalid (m_axi_arvalid),
      .m_axi_arready (m_axi_arready),
      .m_axi_araddr  (m_axi_araddr),
      .m_axi_rvalid  (m_axi_rvalid),
      .m_axi_rready  (m_axi_rready),
      .m_axi_rdata   (m_axi_rdata)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // soft core reset length, after power-on only
   always @(negedge clk) begin
      if (sys_ready && core_reset) begin
         pulse_cycles = pulse_cycles + 1;
      end
   end

   task automatic check_value(input string name, input data_t expected, input data_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s expected %b actual %b", name, expected, actual);
      end
   endtask

   //////////////////////////////
   // native master
   //////////////////////////////
   // request held until ready seen at a falling edge
   task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                             output data_t rdata);
      @(posedge clk);
      #1;
      m_valid = 1'b1;
      m_addr  = addr;
      m_wdata = wdata;
      m_wstrb = wstrb;
      @(negedge clk);
      while (!m_ready) begin
         @(negedge clk);
      end
      rdata = m_rdata;
      @(posedge clk);
      #1;
      m_valid = 1'b0;
      m_wstrb = '0;
   endtask

   //////////////////////////////
   // AXI4-Lite memory model
   //////////////////////////////
   // 0 to 3 idle cycles before a ready or a response
   task automatic random_stall();
      int delay;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
         @(posedge clk);
         #1;
      end
   endtask

   always begin
      @(posedge clk);
      #1;
      if (m_axi_awvalid && m_axi_wvalid) begin
         random_stall();
         m_axi_awready = 1'b1;
         m_axi_wready  = 1'b1;
         last_awaddr   = m_axi_awaddr;
         for (int b = 0; b < 4; b++) begin
            if (m_axi_wstrb[b]) begin
               ext_mem[m_axi_awaddr[9:2]][b*8 +: 8] = m_axi_wdata[b*8 +: 8];
            end
         end
         @(posedge clk);
         #1;
         m_axi_awready = 1'b0;
         m_axi_wready  = 1'b0;
         // bready already up, one cycle response
         random_stall();
         check_bit("axi bready with bvalid", 1'b1, m_axi_bready);
         m_axi_bvalid = 1'b1;
         @(posedge clk);
         #1;
         m_axi_bvalid = 1'b0;
      end else if (m_axi_arvalid) begin
         random_stall();
         m_axi_arready = 1'b1;
         last_araddr   = m_axi_araddr;
         @(posedge clk);
         #1;
         m_axi_arready = 1'b0;
         random_stall();
         check_bit("axi rready with rvalid", 1'b1, m_axi_rready);
         m_axi_rvalid = 1'b1;
         m_axi_rdata  = ext_mem[last_araddr[9:2]];
         @(posedge clk);
         #1;
         m_axi_rvalid = 1'b0;
      end
   end

   // bound grows with the golden file
   initial begin
      wait (n_ops > 0);
      repeat (1024 + 400 * n_ops) @(posedge clk);
      $display("timeout, the golden ops did not finish in %0d cycles", 1024 + 400 * n_ops);
      $display("checks %0d errors %0d", checks, errors + 1);
      $display(">>> FAIL");
      $finish;
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      int      kind;
      addr_t   addr;
      data_t   wdata;
      strb_t   wstrb;
      data_t   expected;
      data_t   rdata;
      reset         = 1'b1;
      m_valid       = 1'b0;
      m_addr        = '0;
      m_wdata       = '0;
      m_wstrb       = '0;
      m_axi_awready = 1'b0;
      m_axi_wready  = 1'b0;
      m_axi_bvalid  = 1'b0;
      m_axi_arready = 1'b0;
      m_axi_rvalid  = 1'b0;
      m_axi_rdata   = '0;
      seed          = 32'h084392ee;
      for (int i = 0; i < MAX_OPS * 5; i++) begin
         golden[i] = '0;
      end
      $readmemh("tests/soc_golden.txt", golden);
      // ops run up to the first end marker
      while (n_ops < MAX_OPS && golden[n_ops*5] != OP_END) begin
         n_ops++;
      end
      if (n_ops == 0) begin
         errors++;
         $display("golden file tests/soc_golden.txt is missing or holds no ops");
      end

      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit("reset sys_ready", 1'b0, sys_ready);
      check_bit("reset core_reset", 1'b1, core_reset);
      check_bit("reset mem_sel", 1'b0, mem_sel);
      check_bit("reset axi valids", 1'b0, m_axi_awvalid || m_axi_wvalid || m_axi_arvalid);
      check_bit("reset axi readies", 1'b0, m_axi_bready || m_axi_rready);
      while (!sys_ready) begin
         @(negedge clk);
      end
      check_bit("core_reset after sys_ready", 1'b0, core_reset);

      for (int i = 0; i < n_ops; i++) begin
         kind     = golden[i*5];
         addr     = golden[i*5+1];
         wdata    = golden[i*5+2];
         wstrb    = golden[i*5+3][3:0];
         expected = golden[i*5+4];
         case (kind)
            OP_WRITE: begin
               bus_access(addr, wdata, wstrb, rdata);
               // region 4 is the AXI side
               if (addr[30:28] == 3'd4) begin
                  check_value($sformatf("axi awaddr line %0d", i), addr, last_awaddr);
               end
            end
            OP_READ: begin
               bus_access(addr, '0, '0, rdata);
               check_value($sformatf("read %h line %0d", addr, i), expected, rdata);
               if (addr[30:28] == 3'd4) begin
                  check_value($sformatf("axi araddr line %0d", i), addr, last_araddr);
               end
            end
            OP_UART_WAIT: begin
               // status bit 1, rx valid
               rdata = '0;
               while (!rdata[1]) begin
                  bus_access(addr, '0, '0, rdata);
               end
            end
            OP_SOFT_RESET: begin
               pulse_cycles = 0;
               bus_access(addr, wdata, wstrb, rdata);
               repeat (expected + 4) @(negedge clk);
               check_value($sformatf("core_reset pulse line %0d", i), expected,
                           data_t'(pulse_cycles));
               check_bit("mem_sel after soft reset", 1'b1, mem_sel);
            end
            default: begin
               errors++;
               $display("golden line %0d has unknown op kind %0d", i, kind);
            end
         endcase
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/soc_golden.txt ====
// kind addr wdata strb expected, all hex
// kind 1 write, 2 read and check, 3 poll uart status, 4 soft reset (expected is pulse length), 0 end
1 00000010 11223344 f 00000000
1 00000010 aabbccdd 5 00000000
2 00000010 00000000 0 11bb33dd
1 10000010 55667788 f 00000000
1 10000010 0000ee00 2 00000000
2 10000010 00000000 0 5566ee88
2 00000010 00000000 0 11bb33dd
1 10000020 cafef00d f 00000000
1 40000040 12345678 f 00000000
1 40000044 9abcdef0 f 00000000
1 40000040 ffff0000 c 00000000
2 40000040 00000000 0 ffff5678
2 40000044 00000000 0 9abcdef0
1 2000000c 00000006 f 00000000
2 2000000c 00000000 0 00000006
1 20000000 000000a5 1 00000000
3 20000004 00000000 0 00000000
2 20000008 00000000 0 000000a5
2 20000004 00000000 0 00000000
2 30000000 00000000 0 00000000
2 70001234 00000000 0 00000000
4 6ffffffc 00000000 f 00000005
2 00000010 00000000 0 5566ee88
2 00000020 00000000 0 cafef00d
2 10000020 00000000 0 cafef00d
0 00000000 00000000 0 00000000

// ==== compile.f ====
+incdir+common
common/soc_pkg.sv
common/native_bus_if.sv
design/reset_ctrl.sv
design/bus_interconnect.sv
design/sram_memory.sv
uart/uart_core.sv
design/axi_lite_bridge.sv
design/soc_system.sv
tests/tb_soc_system.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_soc_system
FILELIST = compile.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
